// File: bus_pkg.sv
//##############################
// word and line types, processor and memory port structs
//##############################

package bus_pkg;

    typedef logic [31:0] word_t;

    localparam int LINE_WORDS = 2;

    typedef word_t [LINE_WORDS-1:0] line_t;    // word 0 sits at the line-aligned address

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;     // low on the completing cycle
        word_t rdata;
    } proc_rsp_t;

    // line writes carry byte_en all ones, uncached ones the lanes to store
    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        line_t      wdata;
        logic [3:0] byte_en;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        line_t rdata;    // whole line at the line-aligned address
    } mem_rsp_t;

endpackage

// File: cache_pkg.sv
//##############################
// cache geometry, address union, tag/frame and refill structs
//##############################

package cache_pkg;

    localparam int N_SETS     = 64;
    localparam int SET_BITS   = 6;
    localparam int BLOCK_BITS = 1;
    localparam int TAG_BITS   = 23;

    localparam bus_pkg::word_t NONCACHE_START = 32'hF000_0000;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [SET_BITS-1:0]   set;
        logic [BLOCK_BITS-1:0] block;
        logic [1:0]            byte_off;
    } cache_addr_t;

    // same word, seen raw or split into fields
    typedef union packed {
        bus_pkg::word_t word;
        cache_addr_t    f;
    } cache_addr_u;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        tag_entry_t     tag;
        bus_pkg::line_t data;
    } frame_t;

    typedef struct packed {
        logic                wen;
        logic [SET_BITS-1:0] set;
        frame_t              frame;
    } array_wr_t;

    typedef struct packed {
        logic           start;        // one-cycle pulse
        logic           victim_dirty;
        bus_pkg::word_t victim_addr;
        bus_pkg::line_t victim_line;
        bus_pkg::word_t fill_addr;
    } refill_req_t;

    typedef struct packed {
        logic           done;         // one-cycle pulse, line valid with it
        bus_pkg::line_t line;
    } refill_rsp_t;

endpackage

// File: cache_array.sv
//##############################
// tag and data storage, lookup and maintenance ports
//##############################

module cache_array (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic [cache_pkg::SET_BITS-1:0] lookup_set,
    output cache_pkg::frame_t              lookup_frame,
    input  cache_pkg::array_wr_t           lookup_wr,
    input  logic                           maint_active,
    input  logic [cache_pkg::SET_BITS-1:0] maint_set,
    output cache_pkg::frame_t              maint_frame,
    input  logic                           maint_clear
);

    logic [cache_pkg::N_SETS-1:0]   valid;
    logic [cache_pkg::N_SETS-1:0]   dirty;
    logic [cache_pkg::TAG_BITS-1:0] tags  [cache_pkg::N_SETS];
    bus_pkg::line_t                 lines [cache_pkg::N_SETS];

    // both ports read combinationally
    assign lookup_frame = '{tag:  '{valid: valid[lookup_set], dirty: dirty[lookup_set],
                                    tag: tags[lookup_set]},
                            data: lines[lookup_set]};
    assign maint_frame  = '{tag:  '{valid: valid[maint_set], dirty: dirty[maint_set],
                                    tag: tags[maint_set]},
                            data: lines[maint_set]};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
        end else if (maint_active) begin    // flush owns the array
            if (maint_clear) begin
                valid[maint_set] <= 1'b0;
                dirty[maint_set] <= 1'b0;
            end
        end else if (lookup_wr.wen) begin
            valid[lookup_wr.set] <= lookup_wr.frame.tag.valid;
            dirty[lookup_wr.set] <= lookup_wr.frame.tag.dirty;
        end
    end

    always_ff @(posedge CLK) begin
        if (!maint_active && lookup_wr.wen) begin
            tags[lookup_wr.set]  <= lookup_wr.frame.tag.tag;
            lines[lookup_wr.set] <= lookup_wr.frame.data;
        end
    end

endmodule

// File: cache_ctrl.sv
//##############################
// hit/miss control, byte merge, refill hand-off, uncached path
//##############################

module cache_ctrl (
    input  logic                           CLK,
    input  logic                           nRST,
    input  bus_pkg::proc_req_t             proc_req,
    output bus_pkg::proc_rsp_t             proc_rsp,
    output logic [cache_pkg::SET_BITS-1:0] lookup_set,
    input  cache_pkg::frame_t              lookup_frame,
    output cache_pkg::array_wr_t           lookup_wr,
    input  logic                           flush_active,
    output cache_pkg::refill_req_t         refill_req,
    input  cache_pkg::refill_rsp_t         refill_rsp,
    output bus_pkg::mem_req_t              unc_req,
    input  bus_pkg::mem_rsp_t              unc_rsp
);

    typedef enum logic {
        IDLE,
        WAIT
    } ctrl_state_t;

    ctrl_state_t            state, next_state;
    cache_pkg::cache_addr_u addr;
    logic                   uncached;
    logic                   hit;

    // enabled lanes of new_w over old_w
    function automatic bus_pkg::word_t merge_bytes(input bus_pkg::word_t old_w,
                                                   input bus_pkg::word_t new_w,
                                                   input logic [3:0] be);
        bus_pkg::word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign addr       = cache_pkg::cache_addr_u'(proc_req.addr);
    assign uncached   = addr.word >= cache_pkg::NONCACHE_START;
    assign lookup_set = addr.f.set;
    assign hit        = lookup_frame.tag.valid && (lookup_frame.tag.tag == addr.f.tag);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state     = state;
        proc_rsp.busy  = 1'b1;
        proc_rsp.rdata = lookup_frame.data[addr.f.block];
        lookup_wr       = '0;
        lookup_wr.set   = addr.f.set;
        lookup_wr.frame = lookup_frame;    // write-hit base, only touched lane changes
        // victim and fill address always prepared, start decides
        refill_req.start        = 1'b0;
        refill_req.victim_dirty = lookup_frame.tag.valid && lookup_frame.tag.dirty;
        refill_req.victim_addr  = {lookup_frame.tag.tag, addr.f.set,
                                   {cache_pkg::BLOCK_BITS{1'b0}}, 2'b00};
        refill_req.victim_line  = lookup_frame.data;
        refill_req.fill_addr    = {addr.f.tag, addr.f.set, {cache_pkg::BLOCK_BITS{1'b0}}, 2'b00};
        unc_req = '0;

        if (uncached) begin
            // straight to memory, busy follows memory
            unc_req.ren     = proc_req.ren;
            unc_req.wen     = proc_req.wen;
            unc_req.addr    = proc_req.addr;
            unc_req.wdata   = {bus_pkg::LINE_WORDS{proc_req.wdata}};
            unc_req.byte_en = proc_req.byte_en;
            proc_rsp.busy   = unc_rsp.busy;
            proc_rsp.rdata  = unc_rsp.rdata[addr.f.block];
        end else if (state == IDLE) begin
            if ((proc_req.ren || proc_req.wen) && !flush_active) begin
                if (hit) begin
                    proc_rsp.busy = 1'b0;
                    if (proc_req.wen) begin
                        lookup_wr.wen = 1'b1;
                        lookup_wr.frame.tag.dirty = 1'b1;
                        lookup_wr.frame.data[addr.f.block] =
                            merge_bytes(lookup_frame.data[addr.f.block], proc_req.wdata,
                                        proc_req.byte_en);
                    end
                end else begin
                    refill_req.start = 1'b1;
                    next_state       = WAIT;
                end
            end
        end else if (refill_rsp.done) begin
            next_state = IDLE;
            // a flush that started meanwhile drops the line, the miss reruns after it
            if (!flush_active) begin
                lookup_wr.wen             = 1'b1;
                lookup_wr.frame.tag.valid = 1'b1;
                lookup_wr.frame.tag.dirty = proc_req.wen;
                lookup_wr.frame.tag.tag   = addr.f.tag;
                lookup_wr.frame.data      = refill_rsp.line;
                if (proc_req.wen) begin
                    lookup_wr.frame.data[addr.f.block] =
                        merge_bytes(refill_rsp.line[addr.f.block], proc_req.wdata,
                                    proc_req.byte_en);
                end
            end
        end
    end

endmodule

// File: line_refill.sv
//##############################
// victim write-back and line fetch sequencer
//##############################

module line_refill (
    input  logic                   CLK,
    input  logic                   nRST,
    input  cache_pkg::refill_req_t refill_req,
    output cache_pkg::refill_rsp_t refill_rsp,
    output bus_pkg::mem_req_t      mem_req,
    input  bus_pkg::mem_rsp_t      mem_rsp
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_WB,
        R_FETCH
    } refill_state_t;

    refill_state_t  state;
    bus_pkg::word_t victim_addr;
    bus_pkg::line_t victim_line;
    bus_pkg::word_t fill_addr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= R_IDLE;
        end else begin
            case (state)
                R_IDLE: begin
                    if (refill_req.start) begin
                        state <= refill_req.victim_dirty ? R_WB : R_FETCH;
                    end
                end
                R_WB: if (!mem_rsp.busy) state <= R_FETCH;
                R_FETCH: if (!mem_rsp.busy) state <= R_IDLE;
                default: state <= R_IDLE;
            endcase
        end
    end

    // snapshot of the miss, the array may change under it
    always_ff @(posedge CLK) begin
        if (state == R_IDLE && refill_req.start) begin
            victim_addr <= refill_req.victim_addr;
            victim_line <= refill_req.victim_line;
            fill_addr   <= refill_req.fill_addr;
        end
    end

    always_comb begin
        mem_req         = '0;
        mem_req.byte_en = '1;    // whole line
        if (state == R_WB) begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = victim_addr;
            mem_req.wdata = victim_line;
        end else if (state == R_FETCH) begin
            mem_req.ren  = 1'b1;
            mem_req.addr = fill_addr;
        end
    end

    assign refill_rsp.done = (state == R_FETCH) && !mem_rsp.busy;
    assign refill_rsp.line = mem_rsp.rdata;

endmodule

// File: flush_engine.sv
//##############################
// flush walker, writes back dirty lines and invalidates
//##############################

module flush_engine (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           flush,
    output logic                           flush_done,
    output logic                           active,
    output logic [cache_pkg::SET_BITS-1:0] maint_set,
    input  cache_pkg::frame_t              maint_frame,
    output logic                           maint_clear,
    output bus_pkg::mem_req_t              mem_req,
    input  bus_pkg::mem_rsp_t              mem_rsp
);

    logic                           pend;      // flush seen, not yet started
    logic [cache_pkg::SET_BITS-1:0] set_cnt;
    logic                           dirty_line;
    logic                           start;
    logic                           step;

    assign dirty_line = maint_frame.tag.valid && maint_frame.tag.dirty;
    assign start      = pend && !active;
    assign step       = active && (!dirty_line || !mem_rsp.busy);    // clean set or wb taken

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pend       <= 1'b0;
            active     <= 1'b0;
            set_cnt    <= '0;
            flush_done <= 1'b0;
        end else begin
            flush_done <= 1'b0;
            if (start) begin
                pend    <= flush;
                active  <= 1'b1;
                set_cnt <= '0;
            end else begin
                if (flush) pend <= 1'b1;
                if (step) begin
                    set_cnt <= set_cnt + 1'b1;
                    if (set_cnt == cache_pkg::SET_BITS'(cache_pkg::N_SETS - 1)) begin
                        active     <= 1'b0;
                        flush_done <= 1'b1;
                    end
                end
            end
        end
    end

    assign maint_set   = set_cnt;
    assign maint_clear = step;

    always_comb begin
        mem_req         = '0;
        mem_req.byte_en = '1;
        mem_req.wen     = active && dirty_line;
        mem_req.addr    = {maint_frame.tag.tag, set_cnt, {cache_pkg::BLOCK_BITS{1'b0}}, 2'b00};
        mem_req.wdata   = maint_frame.data;
    end

endmodule

// File: mem_arbiter.sv
//##############################
// fixed-priority memory port arbiter
//##############################

module mem_arbiter (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::mem_req_t flush_req,
    input  bus_pkg::mem_req_t refill_req,
    input  bus_pkg::mem_req_t unc_req,
    output bus_pkg::mem_rsp_t flush_rsp,
    output bus_pkg::mem_rsp_t refill_rsp,
    output bus_pkg::mem_rsp_t unc_rsp,
    output bus_pkg::mem_req_t mem_req,
    input  bus_pkg::mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        G_NONE,
        G_FLUSH,
        G_REFILL,
        G_UNC
    } grant_t;

    grant_t owner, cur;

    always_comb begin
        if (owner != G_NONE) cur = owner;    // held until completion
        else if (flush_req.ren || flush_req.wen) cur = G_FLUSH;
        else if (refill_req.ren || refill_req.wen) cur = G_REFILL;
        else if (unc_req.ren || unc_req.wen) cur = G_UNC;
        else cur = G_NONE;

        mem_req    = '0;
        flush_rsp  = '{busy: 1'b1, rdata: mem_rsp.rdata};
        refill_rsp = '{busy: 1'b1, rdata: mem_rsp.rdata};
        unc_rsp    = '{busy: 1'b1, rdata: mem_rsp.rdata};
        case (cur)
            G_FLUSH: begin
                mem_req        = flush_req;
                flush_rsp.busy = mem_rsp.busy;
            end
            G_REFILL: begin
                mem_req         = refill_req;
                refill_rsp.busy = mem_rsp.busy;
            end
            G_UNC: begin
                mem_req      = unc_req;
                unc_rsp.busy = mem_rsp.busy;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner <= G_NONE;
        end else if ((mem_req.ren || mem_req.wen) && mem_rsp.busy) begin
            owner <= cur;
        end else begin
            owner <= G_NONE;    // completed or dropped
        end
    end

endmodule

// File: l1_dcache.sv
//##############################
// L1 data cache top level
//##############################

module l1_dcache (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               flush,
    output logic               flush_done,
    input  bus_pkg::proc_req_t proc_req,
    output bus_pkg::proc_rsp_t proc_rsp,
    output bus_pkg::mem_req_t  mem_req,
    input  bus_pkg::mem_rsp_t  mem_rsp
);

    logic [cache_pkg::SET_BITS-1:0] lookup_set;
    cache_pkg::frame_t              lookup_frame;
    cache_pkg::array_wr_t           lookup_wr;
    logic                           flush_active;
    logic [cache_pkg::SET_BITS-1:0] maint_set;
    cache_pkg::frame_t              maint_frame;
    logic                           maint_clear;
    cache_pkg::refill_req_t         refill_req;
    cache_pkg::refill_rsp_t         refill_rsp;
    bus_pkg::mem_req_t              unc_req, refill_mem_req, flush_mem_req;
    bus_pkg::mem_rsp_t              unc_rsp, refill_mem_rsp, flush_mem_rsp;

    cache_array i_array (
        .CLK(CLK), .nRST(nRST),
        .lookup_set(lookup_set), .lookup_frame(lookup_frame), .lookup_wr(lookup_wr),
        .maint_active(flush_active), .maint_set(maint_set), .maint_frame(maint_frame),
        .maint_clear(maint_clear)
    );

    cache_ctrl i_ctrl (
        .CLK(CLK), .nRST(nRST),
        .proc_req(proc_req), .proc_rsp(proc_rsp),
        .lookup_set(lookup_set), .lookup_frame(lookup_frame), .lookup_wr(lookup_wr),
        .flush_active(flush_active),
        .refill_req(refill_req), .refill_rsp(refill_rsp),
        .unc_req(unc_req), .unc_rsp(unc_rsp)
    );

    line_refill i_refill (
        .CLK(CLK), .nRST(nRST),
        .refill_req(refill_req), .refill_rsp(refill_rsp),
        .mem_req(refill_mem_req), .mem_rsp(refill_mem_rsp)
    );

    flush_engine i_flush (
        .CLK(CLK), .nRST(nRST),
        .flush(flush), .flush_done(flush_done), .active(flush_active),
        .maint_set(maint_set), .maint_frame(maint_frame), .maint_clear(maint_clear),
        .mem_req(flush_mem_req), .mem_rsp(flush_mem_rsp)
    );

    mem_arbiter i_arb (
        .CLK(CLK), .nRST(nRST),
        .flush_req(flush_mem_req), .refill_req(refill_mem_req), .unc_req(unc_req),
        .flush_rsp(flush_mem_rsp), .refill_rsp(refill_mem_rsp), .unc_rsp(unc_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

endmodule

// File: tb_mem.sv
//##############################
// memory model, random busy latency, transaction log
//##############################

module tb_mem (
    input  logic              CLK,
    input  logic              nRST,
    input  bus_pkg::mem_req_t mem_req,
    output bus_pkg::mem_rsp_t mem_rsp
);

    typedef struct packed {
        logic           wr;
        bus_pkg::word_t addr;
        bus_pkg::line_t data;
        logic [3:0]     be;
    } xact_t;

    bus_pkg::word_t store [bus_pkg::word_t];    // words written so far
    xact_t          xlog [$];                   // every completed transaction, in order
    logic [31:0]    seed;
    logic           pending;
    logic [1:0]     wait_cnt;
    bus_pkg::line_t rd_line;
    bus_pkg::word_t line_addr;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // untouched words follow the address pattern
    function automatic bus_pkg::word_t peek(input bus_pkg::word_t a);
        if (store.exists(a)) return store[a];
        return a ^ 32'h5A5A_5A5A;
    endfunction

    assign line_addr     = {mem_req.addr[31:3], 3'b000};
    assign mem_rsp.busy  = !(pending && wait_cnt == 2'd0);
    assign mem_rsp.rdata = rd_line;

    always @(posedge CLK, negedge nRST) begin
        bus_pkg::word_t wa;
        bus_pkg::word_t w;
        if (!nRST) begin
            pending  <= 1'b0;
            wait_cnt <= 2'd0;
            seed     <= 32'ha1bf;
        end else if (mem_req.ren || mem_req.wen) begin
            if (!pending) begin
                pending    <= 1'b1;
                wait_cnt   <= seed[17:16];    // 1 to 4 busy cycles in all
                seed       <= lcg_next(seed);
                rd_line[0] <= peek(line_addr);
                rd_line[1] <= peek(line_addr + 32'd4);
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                pending <= 1'b0;    // completing cycle
                if (mem_req.wen && mem_req.addr >= cache_pkg::NONCACHE_START) begin
                    // uncached write keeps the disabled lanes
                    wa = {mem_req.addr[31:2], 2'b00};
                    w  = peek(wa);
                    for (int i = 0; i < 4; i++) begin
                        if (mem_req.byte_en[i]) begin
                            w[8*i +: 8] = mem_req.wdata[mem_req.addr[2]][8*i +: 8];
                        end
                    end
                    store[wa] = w;
                end else if (mem_req.wen) begin
                    store[line_addr]         = mem_req.wdata[0];
                    store[line_addr + 32'd4] = mem_req.wdata[1];
                end
                xlog.push_back('{wr: mem_req.wen, addr: mem_req.addr, data: mem_req.wdata,
                                 be: mem_req.byte_en});
            end
        end else begin
            pending <= 1'b0;
        end
    end

endmodule

// File: tb_top.sv
//##############################
// testbench top, stimulus, shadow memory and checks
//##############################

module tb_top;

    localparam int REQ_TIMEOUT   = 200;
    localparam int FLUSH_TIMEOUT = 2000;

    logic               CLK = 1'b0;
    logic               nRST;
    logic               flush;
    logic               flush_done;
    bus_pkg::proc_req_t proc_req;
    bus_pkg::proc_rsp_t proc_rsp;
    bus_pkg::mem_req_t  mem_req;
    bus_pkg::mem_rsp_t  mem_rsp;

    bus_pkg::word_t shadow [bus_pkg::word_t];    // expected memory, written words only
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_errors0;

    l1_dcache i_dut (
        .CLK(CLK), .nRST(nRST), .flush(flush), .flush_done(flush_done),
        .proc_req(proc_req), .proc_rsp(proc_rsp), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    tb_mem i_mem (.CLK(CLK), .nRST(nRST), .mem_req(mem_req), .mem_rsp(mem_rsp));

    always #5 CLK = ~CLK;

    function automatic bus_pkg::word_t expect_word(input bus_pkg::word_t a);
        bus_pkg::word_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) return shadow[wa];
        return wa ^ 32'h5A5A_5A5A;    // initial content rule
    endfunction

    function automatic bus_pkg::line_t expect_line(input bus_pkg::word_t la);
        bus_pkg::line_t l;
        l[0] = expect_word(la);
        l[1] = expect_word(la + 32'd4);
        return l;
    endfunction

    // enabled bytes from new_w, the rest from old_w
    function automatic bus_pkg::word_t lane_merge(input bus_pkg::word_t old_w,
                                                  input bus_pkg::word_t new_w,
                                                  input logic [3:0] be);
        bus_pkg::word_t m;
        m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~m) | (new_w & m);
    endfunction

    task automatic note_fail(input string msg);
        $display("FAIL t=%0t: %s", $time, msg);
        errors++;
    endtask

    // every completing read is compared with the shadow
    always @(negedge CLK) begin
        if (nRST && proc_req.ren && !proc_rsp.busy) begin
            assert (proc_rsp.rdata == expect_word(proc_req.addr))
                else note_fail($sformatf("read %h gave %h, expected %h", proc_req.addr,
                                         proc_rsp.rdata, expect_word(proc_req.addr)));
        end
    end

    task automatic access(input logic wr, input bus_pkg::word_t addr,
                          input bus_pkg::word_t wdata, input logic [3:0] be,
                          output int cycles);
        int n;
        n = 0;
        @(posedge CLK);
        proc_req <= '{ren: !wr, wen: wr, addr: addr, wdata: wdata, byte_en: be};
        do begin
            @(negedge CLK);
            n++;
        end while (proc_rsp.busy && n < REQ_TIMEOUT);
        cycles = n;
        if (proc_rsp.busy) begin
            $display("timeout: request to %h was never completed", addr);
            errors++;
        end else if (wr) begin
            shadow[{addr[31:2], 2'b00}] = lane_merge(expect_word(addr), wdata, be);
        end
        @(posedge CLK);
        proc_req.ren <= 1'b0;
        proc_req.wen <= 1'b0;
        @(negedge CLK);    // memory log settled
    endtask

    task automatic pulse_flush_and_wait();
        int n;
        n = 0;
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        do begin
            @(negedge CLK);
            n++;
        end while (!flush_done && n < FLUSH_TIMEOUT);
        if (!flush_done) begin
            $display("timeout: flush_done never pulsed");
            errors++;
        end
    endtask

    // logged memory transaction idx against expected kind and address
    task automatic check_xact(input int idx, input logic wr, input bus_pkg::word_t addr);
        assert (i_mem.xlog.size() > idx)
            else note_fail($sformatf("memory transaction %0d never happened", idx));
        if (i_mem.xlog.size() > idx) begin
            assert (i_mem.xlog[idx].wr == wr && i_mem.xlog[idx].addr == addr)
                else note_fail($sformatf("memory xact %0d is wr %b addr %h, expected wr %b addr %h",
                                         idx, i_mem.xlog[idx].wr, i_mem.xlog[idx].addr, wr, addr));
        end
    endtask

    task automatic start_test();
        test_errors0 = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors0);
        end
    endtask

    initial begin
        int             cyc;
        int             mark;
        bus_pkg::line_t ln;
        bus_pkg::word_t fl_lines [4];
        bus_pkg::word_t fl_words [4];
        logic [3:0]     masks [5];
        nRST     <= 1'b0;
        flush    <= 1'b0;
        proc_req <= '0;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;

        start_test();
        @(negedge CLK);
        assert (!mem_req.ren && !mem_req.wen && !flush_done && proc_rsp.busy)
            else note_fail("port state after reset is wrong");
        assert (!i_dut.refill_req.start && !i_dut.refill_rsp.done && !i_dut.flush_active)
            else note_fail("refill or flush engine active after reset");
        assert (i_dut.i_array.valid == '0) else note_fail("valid bits not clear after reset");
        end_test("reset state");

        start_test();
        access(1'b0, 32'h0000_1004, '0, '0, cyc);
        assert (cyc > 1) else note_fail("first read of a cold line did not miss");
        access(1'b0, 32'h0000_1004, '0, '0, cyc);
        assert (cyc == 1) else note_fail($sformatf("read hit took %0d cycles", cyc));
        end_test("cold read then hit");

        start_test();
        masks = '{4'b0001, 4'b0110, 4'b1000, 4'b1111, 4'b0101};
        for (int i = 0; i < 5; i++) begin
            access(1'b1, 32'h0000_1004, 32'hA0B0_C0D0 ^ (bus_pkg::word_t'(i) * 32'h0101_0101),
                   masks[i], cyc);
            assert (cyc == 1) else note_fail($sformatf("write hit took %0d cycles", cyc));
            access(1'b0, 32'h0000_1004, '0, '0, cyc);
        end
        end_test("write hit byte masks");

        start_test();
        access(1'b1, 32'h0000_2010, 32'h1234_5678, 4'b0011, cyc);    // miss, line left dirty
        ln   = expect_line(32'h0000_2010);
        mark = i_mem.xlog.size();
        access(1'b0, 32'h0000_4010, '0, '0, cyc);    // same set, other tag
        check_xact(mark, 1'b1, 32'h0000_2010);
        check_xact(mark + 1, 1'b0, 32'h0000_4010);
        if (i_mem.xlog.size() > mark) begin
            assert (i_mem.xlog[mark].data == ln)
                else note_fail($sformatf("victim line %h, expected %h",
                                         i_mem.xlog[mark].data, ln));
        end
        access(1'b0, 32'h0000_2010, '0, '0, cyc);
        end_test("dirty eviction");

        start_test();
        mark = i_mem.xlog.size();
        access(1'b1, 32'hF000_0104, 32'hCAFE_F00D, 4'b1010, cyc);
        check_xact(mark, 1'b1, 32'hF000_0104);
        if (i_mem.xlog.size() > mark) begin
            assert (i_mem.xlog[mark].be == 4'b1010)
                else note_fail($sformatf("uncached byte_en %b", i_mem.xlog[mark].be));
        end
        access(1'b0, 32'hF000_0104, '0, '0, cyc);
        check_xact(mark + 1, 1'b0, 32'hF000_0104);
        access(1'b0, 32'hF000_0100, '0, '0, cyc);    // neighbour word untouched
        end_test("uncached access");

        start_test();
        access(1'b1, 32'h0000_3028, 32'h5555_0001, 4'b1111, cyc);
        access(1'b1, 32'h0000_3030, 32'h0000_00AB, 4'b0001, cyc);
        access(1'b1, 32'h0000_303C, 32'hBEEF_0000, 4'b1100, cyc);
        fl_lines = '{32'h0000_1000, 32'h0000_3028, 32'h0000_3030, 32'h0000_3038};
        fl_words = '{32'h0000_1004, 32'h0000_3028, 32'h0000_3030, 32'h0000_303C};
        mark     = i_mem.xlog.size();
        pulse_flush_and_wait();
        assert (i_mem.xlog.size() == mark + 4)
            else note_fail($sformatf("flush made %0d memory transactions, expected 4",
                                     i_mem.xlog.size() - mark));
        for (int k = 0; k < 4; k++) begin
            check_xact(mark + k, 1'b1, fl_lines[k]);
            if (i_mem.xlog.size() > mark + k) begin
                assert (i_mem.xlog[mark + k].data == expect_line(fl_lines[k]))
                    else note_fail($sformatf("flushed line %h carries %h", fl_lines[k],
                                             i_mem.xlog[mark + k].data));
            end
        end
        for (int k = 0; k < 4; k++) begin
            mark = i_mem.xlog.size();
            access(1'b0, fl_words[k], '0, '0, cyc);    // written word, refetched
            check_xact(mark, 1'b0, fl_lines[k]);
        end
        end_test("flush");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
bus_pkg.sv
cache_pkg.sv
cache_array.sv
cache_ctrl.sv
line_refill.sv
flush_engine.sv
mem_arbiter.sv
l1_dcache.sv
tb_mem.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_top -f tb.f
out=$(./obj_dir/Vtb_top)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***'
